//--- cache_pkg.sv
/*
 * shared definitions for the data cache
 *   geometry of the 4 KB, 4-way, write-back cache
 *   address field widths and replacement LFSR constants
 *   controller state enum
 */
`default_nettype none

package cache_pkg;

    // bus widths
    localparam int ADDR_W = 32;             // byte address
    localparam int DATA_W = 64;             // one word
    localparam int STRB_W = DATA_W / 8;     // byte strobes per word

    // associativity
    localparam int NUM_WAYS = 4;
    localparam int WAY_W    = 2;

    // sets
    localparam int NUM_SETS = 16;
    localparam int INDEX_W  = 4;

    // line layout of 8 words by 8 bytes
    localparam int BEATS_PER_LINE = 8;      // also beats per burst
    localparam int WORD_SEL_W     = 3;
    localparam int OFFSET_W       = 6;      // byte offset in line with bits 2:0 unused

    /*
     * address split
     *   [31 .. 10] tag
     *   [ 9 ..  6] index
     *   [ 5 ..  3] word in line
     *   [ 2 ..  0] byte in word, ignored
     */
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;   // 22

    // random replacement LFSR x^8 + x^6 + x^5 + x^4 + 1
    localparam int               LFSR_W    = 8;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 8'h01;

    // controller FSM
    typedef enum logic [1:0] {
        ST_IDLE,        // wait for a request
        ST_TAG_CHECK,   // lookup, complete on hit
        ST_WRITEBACK,   // dirty victim out to memory
        ST_FILL         // line in from memory
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- tag_store.sv
/*
 * tag, valid and dirty storage
 *   one entry per way per set
 *   all ways of the addressed set shown combinationally
 *   install on fill, dirty mark on write hit
 */
`timescale 1ns/1ps
`default_nettype none

module tag_store
    import cache_pkg::*;
(
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic [INDEX_W-1:0]               index,
    output logic      [NUM_WAYS-1:0][TAG_W-1:0]   way_tags,
    output logic      [NUM_WAYS-1:0]              way_valid,
    output logic      [NUM_WAYS-1:0]              way_dirty,
    input  wire logic                             tag_we,
    input  wire logic [WAY_W-1:0]                 fill_way,
    input  wire logic [TAG_W-1:0]                 fill_tag,
    input  wire logic                             fill_dirty,
    input  wire logic                             dirty_set,
    input  wire logic [WAY_W-1:0]                 hit_way
);

    logic [NUM_WAYS-1:0][TAG_W-1:0] tags  [NUM_SETS];
    logic [NUM_WAYS-1:0]            valid [NUM_SETS];
    logic [NUM_WAYS-1:0]            dirty [NUM_SETS];

    // new tag installed with the last fill beat
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tags[index][fill_way] <= fill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;             // whole cache empty
                dirty[s] <= '0;
            end
        end else if (tag_we) begin
            valid[index][fill_way] <= 1'b1;
            dirty[index][fill_way] <= fill_dirty;
        end else if (dirty_set) begin
            dirty[index][hit_way] <= 1'b1;  // write hit
        end
    end

    assign way_tags  = tags[index];
    assign way_valid = valid[index];
    assign way_dirty = dirty[index];

endmodule

`default_nettype wire

//--- data_store.sv
/*
 * line data storage
 *   512 words, addressed by way, set and word in line
 *   byte-strobed synchronous write
 *   asynchronous read for hit data and write-back beats
 */
`timescale 1ns/1ps
`default_nettype none

module data_store
    import cache_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  wr_en,
    input  wire logic [WAY_W-1:0]      way,
    input  wire logic [INDEX_W-1:0]    index,
    input  wire logic [WORD_SEL_W-1:0] word_sel,
    input  wire logic [DATA_W-1:0]     wdata,
    input  wire logic [STRB_W-1:0]     wstrb,
    output logic      [DATA_W-1:0]     rdata
);

    localparam int DEPTH  = NUM_WAYS * NUM_SETS * BEATS_PER_LINE;
    localparam int ADDR_B = WAY_W + INDEX_W + WORD_SEL_W;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [ADDR_B-1:0] addr;

    assign addr = {way, index, word_sel};   // way-major layout

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb[b]) begin
                    mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // combinational read for same-cycle data
    assign rdata = mem[addr];

endmodule

`default_nettype wire

//--- way_select.sv
/*
 * way selection for one set
 *   hit detection, lowest matching valid way
 *   fill way, lowest invalid way or LFSR pick when full
 *   victim dirty flag and tag for write-back
 */
`timescale 1ns/1ps
`default_nettype none

module way_select
    import cache_pkg::*;
(
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic [TAG_W-1:0]                lookup_tag,
    input  wire logic [NUM_WAYS-1:0][TAG_W-1:0]  way_tags,
    input  wire logic [NUM_WAYS-1:0]             way_valid,
    input  wire logic [NUM_WAYS-1:0]             way_dirty,
    input  wire logic                            advance,
    output logic                                 hit,
    output logic      [WAY_W-1:0]                hit_way,
    output logic      [WAY_W-1:0]                fill_way,
    output logic                                 victim_dirty,
    output logic      [TAG_W-1:0]                victim_tag
);

    logic [LFSR_W-1:0] lfsr;
    logic              set_full;
    logic [WAY_W-1:0]  free_way;

    // scan downwards so the lowest way wins
    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        free_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (way_valid[w] && way_tags[w] == lookup_tag) begin
                hit     = 1'b1;
                hit_way = WAY_W'(w);
            end
            if (!way_valid[w]) begin
                free_way = WAY_W'(w);
            end
        end
    end

    assign set_full     = &way_valid;
    assign fill_way     = set_full ? lfsr[WAY_W-1:0] : free_way;
    assign victim_dirty = way_valid[fill_way] & way_dirty[fill_way];   // invalid way is clean
    assign victim_tag   = way_tags[fill_way];

    // random way only consumed when the set was full
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= LFSR_SEED;
        end else if (advance && set_full) begin
            lfsr <= {lfsr[LFSR_W-2:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

endmodule

`default_nettype wire

//--- cache_ctrl.sv
/*
 * cache controller
 *   request capture and address split
 *   FSM for lookup, write-back and line fill
 *   beat counter shared by both memory bursts
 *   steering of the tag and data store controls
 */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
    import cache_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    // cpu request
    input  wire logic                  req_valid,
    input  wire logic                  req_write,
    input  wire logic [ADDR_W-1:0]     req_addr,
    input  wire logic [DATA_W-1:0]     req_wdata,
    input  wire logic [STRB_W-1:0]     req_strb,
    output logic                       req_ready,
    output logic      [DATA_W-1:0]     rsp_rdata,
    // way selector
    input  wire logic                  hit,
    input  wire logic [WAY_W-1:0]      hit_way,
    input  wire logic [WAY_W-1:0]      fill_way,
    input  wire logic                  victim_dirty,
    input  wire logic [TAG_W-1:0]      victim_tag,
    output logic                       advance,
    output logic      [TAG_W-1:0]      lookup_tag,
    // tag store
    output logic      [INDEX_W-1:0]    index,
    output logic                       tag_we,
    output logic                       fill_dirty,
    output logic                       dirty_set,
    // data store
    output logic      [WAY_W-1:0]      store_way,
    output logic      [WORD_SEL_W-1:0] word_sel,
    output logic                       store_we,
    output logic      [DATA_W-1:0]     store_wdata,
    output logic      [STRB_W-1:0]     store_wstrb,
    input  wire logic [DATA_W-1:0]     store_rdata,
    // memory write channel
    output logic                       mem_w_valid,
    output logic      [ADDR_W-1:0]     mem_w_addr,
    output logic      [DATA_W-1:0]     mem_w_data,
    input  wire logic                  mem_w_ready,
    // memory read channel
    output logic                       mem_r_ready,
    output logic      [ADDR_W-1:0]     mem_r_addr,
    input  wire logic                  mem_r_valid,
    input  wire logic [DATA_W-1:0]     mem_r_data
);

    ctrl_state_t state, state_next;

    // captured request
    logic                  write_q;
    logic [TAG_W-1:0]      tag_q;
    logic [INDEX_W-1:0]    index_q;
    logic [WORD_SEL_W-1:0] word_q;
    logic [DATA_W-1:0]     wdata_q;
    logic [STRB_W-1:0]     strb_q;

    logic [WORD_SEL_W-1:0] beat_cnt;
    logic                  beat_xfer;
    logic                  last_beat;

    assign last_beat = (beat_cnt == WORD_SEL_W'(BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_valid) begin
            write_q <= req_write;
            tag_q   <= req_addr[ADDR_W-1 -: TAG_W];
            index_q <= req_addr[OFFSET_W +: INDEX_W];
            word_q  <= req_addr[OFFSET_W-1 -: WORD_SEL_W];
            wdata_q <= req_wdata;
            strb_q  <= req_strb;
        end
    end

    always_comb begin
        state_next  = state;
        req_ready   = 1'b0;
        advance     = 1'b0;
        tag_we      = 1'b0;
        dirty_set   = 1'b0;
        store_we    = 1'b0;
        store_way   = fill_way;             // victim or fill target
        word_sel    = beat_cnt;
        store_wdata = mem_r_data;
        store_wstrb = '1;                   // fills write whole words
        mem_w_valid = 1'b0;
        mem_r_ready = 1'b0;
        beat_xfer   = 1'b0;
        case (state)
            ST_IDLE: begin
                if (req_valid) begin
                    state_next = ST_TAG_CHECK;
                end
            end
            ST_TAG_CHECK: begin
                store_way   = hit_way;
                word_sel    = word_q;
                store_wdata = wdata_q;
                store_wstrb = strb_q;
                if (hit) begin
                    req_ready  = 1'b1;
                    store_we   = write_q;
                    dirty_set  = write_q;
                    state_next = ST_IDLE;
                end else if (victim_dirty) begin
                    state_next = ST_WRITEBACK;
                end else begin
                    state_next = ST_FILL;
                end
            end
            ST_WRITEBACK: begin
                mem_w_valid = 1'b1;
                beat_xfer   = mem_w_ready;
                if (mem_w_ready && last_beat) begin
                    state_next = ST_FILL;
                end
            end
            ST_FILL: begin
                mem_r_ready = 1'b1;
                beat_xfer   = mem_r_valid;
                store_we    = mem_r_valid;
                if (mem_r_valid && last_beat) begin
                    tag_we     = 1'b1;      // install clean line
                    advance    = 1'b1;
                    state_next = ST_TAG_CHECK;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_next;
            if (beat_xfer) begin
                beat_cnt <= beat_cnt + 1'b1;    // wraps after word 7
            end else if (state == ST_TAG_CHECK) begin
                beat_cnt <= '0;
            end
        end
    end

    assign lookup_tag = tag_q;
    assign index      = index_q;
    assign fill_dirty = 1'b0;
    assign rsp_rdata  = store_rdata;

    // write-back goes to the victim's own line
    assign mem_w_addr = {victim_tag, index_q, {OFFSET_W{1'b0}}};
    assign mem_w_data = store_rdata;
    assign mem_r_addr = {tag_q, index_q, {OFFSET_W{1'b0}}};

endmodule

`default_nettype wire

//--- cache_top.sv
/*
 * data cache top level
 *   controller, way selector, tag store and data store
 */
`timescale 1ns/1ps
`default_nettype none

module cache_top
    import cache_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    // cpu request
    input  wire logic              req_valid,
    input  wire logic              req_write,
    input  wire logic [ADDR_W-1:0] req_addr,
    input  wire logic [DATA_W-1:0] req_wdata,
    input  wire logic [STRB_W-1:0] req_strb,
    output logic                   req_ready,
    output logic      [DATA_W-1:0] rsp_rdata,
    // memory write channel
    output logic                   mem_w_valid,
    output logic      [ADDR_W-1:0] mem_w_addr,
    output logic      [DATA_W-1:0] mem_w_data,
    input  wire logic              mem_w_ready,
    // memory read channel
    output logic                   mem_r_ready,
    output logic      [ADDR_W-1:0] mem_r_addr,
    input  wire logic              mem_r_valid,
    input  wire logic [DATA_W-1:0] mem_r_data
);

    logic [NUM_WAYS-1:0][TAG_W-1:0] way_tags;
    logic [NUM_WAYS-1:0]            way_valid;
    logic [NUM_WAYS-1:0]            way_dirty;
    logic                           hit;
    logic [WAY_W-1:0]               hit_way;
    logic [WAY_W-1:0]               fill_way;
    logic                           victim_dirty;
    logic [TAG_W-1:0]               victim_tag;
    logic                           advance;
    logic [TAG_W-1:0]               lookup_tag;
    logic [INDEX_W-1:0]             index;
    logic                           tag_we;
    logic                           fill_dirty;
    logic                           dirty_set;
    logic [WAY_W-1:0]               store_way;
    logic [WORD_SEL_W-1:0]          word_sel;
    logic                           store_we;
    logic [DATA_W-1:0]              store_wdata;
    logic [STRB_W-1:0]              store_wstrb;
    logic [DATA_W-1:0]              store_rdata;

    cache_ctrl u_ctrl (
        .clk, .rst,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_strb,
        .req_ready, .rsp_rdata,
        .hit, .hit_way, .fill_way, .victim_dirty, .victim_tag,
        .advance, .lookup_tag,
        .index, .tag_we, .fill_dirty, .dirty_set,
        .store_way, .word_sel, .store_we, .store_wdata, .store_wstrb, .store_rdata,
        .mem_w_valid, .mem_w_addr, .mem_w_data, .mem_w_ready,
        .mem_r_ready, .mem_r_addr, .mem_r_valid, .mem_r_data
    );

    way_select u_way_select (
        .clk, .rst,
        .lookup_tag, .way_tags, .way_valid, .way_dirty,
        .advance,
        .hit, .hit_way, .fill_way, .victim_dirty, .victim_tag
    );

    tag_store u_tag_store (
        .clk, .rst,
        .index, .way_tags, .way_valid, .way_dirty,
        .tag_we, .fill_way, .fill_tag(lookup_tag), .fill_dirty,
        .dirty_set, .hit_way
    );

    data_store u_data_store (
        .clk,
        .wr_en    (store_we),
        .way      (store_way),
        .index,
        .word_sel,
        .wdata    (store_wdata),
        .wstrb    (store_wstrb),
        .rdata    (store_rdata)
    );

endmodule

`default_nettype wire

//--- tb_mem_model.sv
/*
 * testbench memory for the cache
 *   64 KB of 64-bit words with an address-based start pattern
 *   answers write-back and fill bursts, word 0 first
 *   optional random stalls on both channels
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        stall_en,
    input  wire logic        mem_w_valid,
    input  wire logic [31:0] mem_w_addr,
    input  wire logic [63:0] mem_w_data,
    output logic             mem_w_ready,
    input  wire logic        mem_r_ready,
    input  wire logic [31:0] mem_r_addr,
    output logic             mem_r_valid,
    output logic      [63:0] mem_r_data
);

    localparam int WORDS = 8192;        // 64 KB

    logic [63:0] mem [WORDS];
    logic [2:0]  w_beat;                // write channel word in line
    logic [2:0]  r_beat;                // read channel word in line
    integer      seed = 59;

    function automatic logic [63:0] pattern(input logic [31:0] byte_addr);
        return {byte_addr ^ 32'h1357_9bdf, ~byte_addr};
    endfunction

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] <= pattern(32'(i * 8));
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            mem_w_ready <= 1'b0;
            mem_r_valid <= 1'b0;
            w_beat      <= '0;
            r_beat      <= '0;
        end else begin
            // ready or valid about three cycles in four when stalling
            mem_w_ready <= stall_en ? (($random(seed) & 3) != 0) : 1'b1;
            mem_r_valid <= stall_en ? (($random(seed) & 3) != 0) : 1'b1;
            if (mem_w_valid && mem_w_ready) begin
                mem[{mem_w_addr[15:6], w_beat}] <= mem_w_data;
                w_beat <= w_beat + 3'd1;    // wraps after word 7
            end
            if (mem_r_valid && mem_r_ready) begin
                r_beat <= r_beat + 3'd1;
            end
        end
    end

    assign mem_r_data = mem[{mem_r_addr[15:6], r_beat}];

endmodule

`default_nettype wire

//--- tb_cache_top.sv
/*
 * testbench for the data cache
 *   clock, reset, memory model and shadow memory
 *   burst monitors on both memory channels
 *   directed tests for hits, misses, strobes and evictions
 */
`timescale 1ns/1ps
`default_nettype none

module tb_cache_top;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int MEM_WORDS    = 8192;
    localparam int NUM_REQS     = 70;   // upper bound over all tests
    localparam int REQ_CYCLES   = 40;   // write-back plus fill with stalls
    localparam int MARGIN       = 200;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_write;
    logic [31:0] req_addr;
    logic [63:0] req_wdata;
    logic [7:0]  req_strb;
    logic        req_ready;
    logic [63:0] rsp_rdata;
    logic        mem_w_valid, mem_w_ready, mem_r_ready, mem_r_valid;
    logic [31:0] mem_w_addr, mem_r_addr;
    logic [63:0] mem_w_data, mem_r_data;
    logic        stall_en;

    logic [63:0] shadow [MEM_WORDS];    // expected memory contents
    int errors      = 0;
    int test_errors = 0;
    int checks      = 0;
    int tests_run   = 0;
    int fill_beats  = 0;
    int wb_beats    = 0;
    int fill_burst  = 0;                // beats seen in the open burst
    int wb_burst    = 0;

    cache_top UUT (
        .clk, .rst,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_strb, .req_ready, .rsp_rdata,
        .mem_w_valid, .mem_w_addr, .mem_w_data, .mem_w_ready,
        .mem_r_ready, .mem_r_addr, .mem_r_valid, .mem_r_data
    );

    tb_mem_model u_mem (
        .clk, .rst, .stall_en,
        .mem_w_valid, .mem_w_addr, .mem_w_data, .mem_w_ready,
        .mem_r_ready, .mem_r_addr, .mem_r_valid, .mem_r_data
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((RESET_CYCLES + NUM_REQS * REQ_CYCLES + MARGIN) * CLK_PERIOD);
        $display("watchdog expired, a request or burst never completed");
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [63:0] initial_word(input logic [31:0] byte_addr);
        return {byte_addr ^ 32'h1357_9bdf, ~byte_addr};
    endfunction

    function automatic logic [31:0] line_addr(input int tag, input int index, input int word);
        return {16'h0, tag[5:0], index[3:0], word[2:0], 3'b000};
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("ERROR: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // beats sampled at the falling edge before their transfer edge
    always @(negedge clk) begin
        if (!rst) begin
            if (mem_r_valid && mem_r_ready) begin
                compare("mem_r_addr", 64'(mem_r_addr[5:0]), 64'h0);
                fill_beats++;
                fill_burst++;
            end else if (!mem_r_ready && fill_burst != 0) begin
                compare("fill burst beats", 64'(fill_burst), 64'd8);
                fill_burst = 0;
            end
            if (mem_w_valid && mem_w_ready) begin
                compare("mem_w_addr", 64'(mem_w_addr[5:0]), 64'h0);
                compare("mem_w_data", mem_w_data, shadow[{mem_w_addr[15:6], wb_burst[2:0]}]);
                wb_beats++;
                wb_burst++;
            end else if (!mem_w_valid && wb_burst != 0) begin
                compare("write-back burst beats", 64'(wb_burst), 64'd8);
                wb_burst = 0;
            end
        end
    end

    task automatic cpu_access(input logic write, input logic [31:0] addr, input logic [63:0] wdata,
                              input logic [7:0] strb, output logic [63:0] rdata);
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= write;
        req_addr  <= addr;
        req_wdata <= wdata;
        req_strb  <= strb;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        rdata = rsp_rdata;
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic read_check(input logic [31:0] addr);
        logic [63:0] data;
        cpu_access(1'b0, addr, 64'h0, 8'h00, data);
        compare("rsp_rdata", data, shadow[addr[15:3]]);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [63:0] data,
                              input logic [7:0] strb);
        logic [63:0] ignored;
        cpu_access(1'b1, addr, data, strb, ignored);
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                shadow[addr[15:3]][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %0d %s done, %0d errors", tests_run, name, test_errors);
        test_errors = 0;
    endtask

    task automatic test_reset();
        @(negedge clk);
        compare("req_ready", 64'(req_ready), 64'h0);
        compare("mem_w_valid", 64'(mem_w_valid), 64'h0);
        compare("mem_r_ready", 64'(mem_r_ready), 64'h0);
        read_check(line_addr(1, 0, 0));
        finish_test("reset");
    endtask

    task automatic test_read_miss_hit();
        int fills0;
        int wb0;
        fills0 = fill_beats;
        read_check(line_addr(2, 3, 5));
        compare("mem_r beats on miss", 64'(fill_beats - fills0), 64'd8);
        fills0 = fill_beats;
        wb0    = wb_beats;
        for (int w = 0; w < 8; w++) begin
            read_check(line_addr(2, 3, w));
        end
        compare("mem_r beats on hits", 64'(fill_beats - fills0), 64'd0);
        compare("mem_w beats on hits", 64'(wb_beats - wb0), 64'd0);
        finish_test("read miss then hit");
    endtask

    task automatic test_write_hit_strobe();
        int fills0;
        fills0 = fill_beats;
        write_word(line_addr(2, 3, 2), 64'hfeed_face_cafe_beef, 8'b1010_0101);
        read_check(line_addr(2, 3, 2));
        write_word(line_addr(2, 3, 2), 64'h0123_4567_89ab_cdef, 8'h0f);
        read_check(line_addr(2, 3, 2));
        write_word(line_addr(2, 3, 7), 64'h5500_0000_0000_00aa, 8'h81);
        read_check(line_addr(2, 3, 7));
        compare("mem_r beats on write hits", 64'(fill_beats - fills0), 64'd0);
        finish_test("write hit with strobes");
    endtask

    task automatic test_write_miss();
        int fills0;
        fills0 = fill_beats;
        write_word(line_addr(5, 7, 4), 64'hdead_beef_0bad_f00d, 8'hf0);
        compare("mem_r beats on write miss", 64'(fill_beats - fills0), 64'd8);
        read_check(line_addr(5, 7, 4));
        read_check(line_addr(5, 7, 3));     // neighbour came in with the fill
        finish_test("write miss allocate");
    endtask

    // six tags into one set of four ways
    task automatic evict_sequence(input int index, input logic [63:0] base);
        int          wb0;
        logic [63:0] data;
        wb0 = wb_beats;
        for (int t = 8; t < 14; t++) begin
            data = base + 64'(t) * 64'h0101_0101_0101_0101;
            write_word(line_addr(t, index, 0), data, 8'hff);
            write_word(line_addr(t, index, 7), ~data, 8'h3c);
        end
        if (wb_beats - wb0 < 16) begin
            errors++;
            test_errors++;
            $display("set %0d saw only %0d write-back beats", index, wb_beats - wb0);
        end
        for (int t = 8; t < 14; t++) begin
            read_check(line_addr(t, index, 0));
            read_check(line_addr(t, index, 7));
        end
    endtask

    task automatic test_dirty_evict();
        evict_sequence(9, 64'h1111_2222_3333_4444);
        finish_test("dirty eviction");
    endtask

    task automatic test_backpressure();
        @(posedge clk);
        stall_en <= 1'b1;
        evict_sequence(12, 64'h9abc_def0_1234_5678);
        @(posedge clk);
        stall_en <= 1'b0;
        finish_test("back-pressure");
    endtask

    initial begin
        rst       <= 1'b1;
        req_valid <= 1'b0;
        req_write <= 1'b0;
        req_addr  <= '0;
        req_wdata <= '0;
        req_strb  <= '0;
        stall_en  <= 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = initial_word(32'(i * 8));
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_read_miss_hit();
        test_write_hit_strobe();
        test_write_miss();
        test_dirty_evict();
        test_backpressure();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
cache_pkg.sv
tag_store.sv
data_store.sv
way_select.sv
cache_ctrl.sv
cache_top.sv
tb_mem_model.sv
tb_cache_top.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, and judge the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_cache_top -f build.f -o sim_cache
./obj_dir/sim_cache | tee sim.log
if grep -q "\*\* FAIL \*\*" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
